// File: flist.f
logic/mat_pkg.sv
logic/processing_element.sv
logic/systolic_array.sv
logic/operand_skew.sv
logic/result_packer.sv
logic/operand_bank.sv
logic/matmul_ctrl.sv
logic/matmul_top.sv
test/tb_matmul.sv

// File: run.sh
#!/bin/sh
# build and run the matrix multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
  -f flist.f \
  --top-module tb_matmul \
  -o tb_matmul

./obj_dir/tb_matmul | tee sim.log

# pass only if the testbench printed its pass line
grep -q "SIMULATION PASSED" sim.log
echo "run.sh: simulation passed"

// File: test/tb_matmul.sv
`timescale 1ns/1ns

module tb_matmul;

  localparam int n = mat_pkg::default_mat_size;
  localparam int dw = mat_pkg::data_w;
  localparam int reset_cycles = 5;
  // load, compute and readback of one test
  localparam int test_bound = 60;
  localparam int cycle_limit = 6 * test_bound + reset_cycles;
  // feed, drain and write take about 20 cycles
  localparam int done_wait = 40;

  logic           clk = 1'b0;
  logic           reset;
  logic           load_en;
  logic           read_en;
  logic           we_a;
  logic           we_b;
  mat_pkg::addr_t addr;
  mat_pkg::word_t data_in;
  mat_pkg::word_t data_out;
  logic           start_mat_mul;
  logic           done_mat_mul;

  integer seed;
  int     cycle_count = 0;
  int     error_count = 0;
  int     tests_run = 0;
  int     tests_failed = 0;

  // operands as matrices, a_mat[row][col]
  mat_pkg::data_t a_mat [n][n];
  mat_pkg::data_t b_mat [n][n];

  // readback check strobe and what it compares against
  logic           check_c;
  mat_pkg::addr_t check_addr;
  mat_pkg::word_t exp_word;
  mat_pkg::word_t pad_mask;

  matmul_top u_dut (
    .clk(clk),
    .reset(reset),
    .load_en(load_en),
    .read_en(read_en),
    .we_a(we_a),
    .we_b(we_b),
    .addr(addr),
    .data_in(data_in),
    .data_out(data_out),
    .start_mat_mul(start_mat_mul),
    .done_mat_mul(done_mat_mul)
  );

  always #5 clk = ~clk;

  // hard stop for a stuck run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run stopped: cycle limit of %0d reached", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // C word must equal the model
  c_value: assert property (@(posedge clk) check_c |-> data_out == exp_word)
    else begin
      error_count++;
      $display("** Error at %0t ns: C[%0d] is %h, expected %h",
        $time, check_addr, $sampled(data_out), exp_word);
    end

  // lanes whose column lies outside the matrix read zero
  c_pad_zero: assert property (@(posedge clk) check_c |-> (data_out & pad_mask) == '0)
    else begin
      error_count++;
      $display("** Error at %0t ns: C[%0d] has nonzero pad lanes in %h",
        $time, check_addr, $sampled(data_out));
    end

  // no done without start
  done_idle: assert property (@(posedge clk) disable iff (reset)
    !start_mat_mul |=> !done_mat_mul)
    else begin
      error_count++;
      $display("** Error at %0t ns: done_mat_mul high while start is low", $time);
    end

  // reference C word for diagonal d, sums wrap at 32 bits then clamp
  function automatic mat_pkg::word_t model_word(input int d);
    mat_pkg::word_t w;
    logic [31:0]    sum;
    int             j;
    w = '0;
    for (int i = 0; i < n; i++) begin
      j = d - i;
      if (j >= 0 && j < n) begin
        sum = '0;
        for (int k = 0; k < n; k++) begin
          sum += 32'(a_mat[i][k]) * 32'(b_mat[k][j]);
        end
        w[i*dw +: dw] = (sum > 32'hffff) ? 16'hffff : sum[15:0];
      end
    end
    return w;
  endfunction

  // ones in every lane whose column d-i is off the matrix
  function automatic mat_pkg::word_t outside_mask(input int d);
    mat_pkg::word_t m;
    m = '0;
    for (int i = 0; i < mat_pkg::lanes; i++) begin
      if (d - i < 0 || d - i >= n) begin
        m[i*dw +: dw] = '1;
      end
    end
    return m;
  endfunction

  task automatic fill_random();
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      for (int k = 0; k < n; k++) begin
        r = $random(seed);
        a_mat[i][k] = {8'h00, r[7:0]};
        r = $random(seed);
        b_mat[i][k] = {8'h00, r[7:0]};
      end
    end
  endtask

  task automatic write_word(input logic to_b, input int where, input mat_pkg::word_t word);
    @(negedge clk);
    load_en = 1'b1;
    we_a = !to_b;
    we_b = to_b;
    addr = mat_pkg::addr_t'(where);
    data_in = word;
  endtask

  // A goes in as column words, B as row words
  task automatic load_operands();
    mat_pkg::word_t a_word;
    mat_pkg::word_t b_word;
    for (int k = 0; k < n; k++) begin
      a_word = '0;
      b_word = '0;
      for (int i = 0; i < n; i++) begin
        a_word[i*dw +: dw] = a_mat[i][k];
        b_word[i*dw +: dw] = b_mat[k][i];
      end
      write_word(1'b0, k, a_word);
      write_word(1'b1, k, b_word);
    end
    @(negedge clk);
    load_en = 1'b0;
    we_a = 1'b0;
    we_b = 1'b0;
    // last write lands one edge later
    @(negedge clk);
  endtask

  task automatic compute();
    int waited;
    waited = 0;
    @(negedge clk);
    start_mat_mul = 1'b1;
    @(negedge clk);
    while (!done_mat_mul && waited < done_wait) begin
      @(negedge clk);
      waited++;
    end
    if (!done_mat_mul) begin
      error_count++;
      $display("done_mat_mul did not rise within %0d cycles of start", done_wait);
    end else begin
      // start stays up one more cycle while done holds after the write burst
      @(negedge clk);
    end
    start_mat_mul = 1'b0;
  endtask

  // pipelined readback, word d is checked while d+1 is addressed
  task automatic read_back();
    for (int d = 0; d <= 2 * n - 1; d++) begin
      @(negedge clk);
      if (d < 2 * n - 1) begin
        read_en = 1'b1;
        addr = mat_pkg::addr_t'(d);
      end else begin
        read_en = 1'b0;
      end
      if (d > 0) begin
        check_c = 1'b1;
        check_addr = mat_pkg::addr_t'(d - 1);
        exp_word = model_word(d - 1);
        pad_mask = outside_mask(d - 1);
      end
    end
    @(negedge clk);
    check_c = 1'b0;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic run_test(input string name);
    int errors_before;
    errors_before = error_count;
    load_operands();
    compute();
    read_back();
    finish_test(name, errors_before);
  endtask

  initial begin
    int errors_before;
    seed = 32'hc9fe;
    reset = 1'b1;
    load_en = 1'b0;
    read_en = 1'b0;
    we_a = 1'b0;
    we_b = 1'b0;
    addr = '0;
    data_in = '0;
    start_mat_mul = 1'b0;
    check_c = 1'b0;
    check_addr = '0;
    exp_word = '0;
    pad_mask = '0;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;

    // quiet after reset, done must stay low
    errors_before = error_count;
    repeat (8) @(negedge clk);
    finish_test("idle_done_low", errors_before);

    // identity A passes B through
    fill_random();
    for (int i = 0; i < n; i++) begin
      for (int k = 0; k < n; k++) begin
        a_mat[i][k] = (i == k) ? 16'd1 : 16'd0;
      end
    end
    run_test("identity_a");

    fill_random();
    run_test("random_small");

    // row 1 of A and column 2 of B push C[1][2] to 4*65536
    fill_random();
    for (int k = 0; k < n; k++) begin
      a_mat[1][k] = 16'h0100;
      b_mat[k][2] = 16'h0100;
    end
    run_test("saturation");

    // fresh data after the previous run, stale sums would show here
    fill_random();
    run_test("second_run_clean");

    $display("tests run %0d, failed %0d, check errors %0d",
      tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: logic/matmul_top.sv
`timescale 1ns/1ns

module matmul_top #(
  parameter int mat_size = mat_pkg::default_mat_size
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           load_en,
  input  logic           read_en,
  input  logic           we_a,
  input  logic           we_b,
  input  mat_pkg::addr_t addr,
  input  mat_pkg::word_t data_in,
  output mat_pkg::word_t data_out,
  input  logic           start_mat_mul,
  output logic           done_mat_mul
);

  // engine side addresses and strobes
  mat_pkg::addr_t a_addr;
  mat_pkg::addr_t b_addr;
  mat_pkg::addr_t c_addr;
  mat_pkg::addr_t diag_index;
  logic           operand_valid;
  logic           acc_clear;
  logic           c_we;

  // operand words straight from the banks, then staggered
  mat_pkg::word_t a_word;
  mat_pkg::word_t b_word;
  mat_pkg::word_t a_skewed;
  mat_pkg::word_t b_skewed;
  mat_pkg::word_t c_word;

  mat_pkg::acc_t acc [mat_size*mat_size];

  // A bank, host writes while load_en is high
  operand_bank u_bank_a (
    .clk(clk),
    .reset(reset),
    .host_sel(load_en),
    .host_addr(addr),
    .engine_addr(a_addr),
    .we(we_a),
    .wdata(data_in),
    .rdata(a_word)
  );

  operand_bank u_bank_b (
    .clk(clk),
    .reset(reset),
    .host_sel(load_en),
    .host_addr(addr),
    .engine_addr(b_addr),
    .we(we_b),
    .wdata(data_in),
    .rdata(b_word)
  );

  // C bank is written by the engine, read back by the host
  operand_bank u_bank_c (
    .clk(clk),
    .reset(reset),
    .host_sel(read_en),
    .host_addr(addr),
    .engine_addr(c_addr),
    .we(c_we),
    .wdata(c_word),
    .rdata(data_out)
  );

  matmul_ctrl #(.mat_size(mat_size)) u_ctrl (
    .clk(clk),
    .reset(reset),
    .start_mat_mul(start_mat_mul),
    .load_en(load_en),
    .read_en(read_en),
    .we_a(we_a),
    .we_b(we_b),
    .a_addr(a_addr),
    .b_addr(b_addr),
    .c_addr(c_addr),
    .operand_valid(operand_valid),
    .acc_clear(acc_clear),
    .c_we(c_we),
    .diag_index(diag_index),
    .done_mat_mul(done_mat_mul)
  );

  operand_skew #(.mat_size(mat_size)) u_skew_a (
    .clk(clk),
    .reset(reset),
    .operand_valid(operand_valid),
    .lanes_in(a_word),
    .lanes_out(a_skewed)
  );

  operand_skew #(.mat_size(mat_size)) u_skew_b (
    .clk(clk),
    .reset(reset),
    .operand_valid(operand_valid),
    .lanes_in(b_word),
    .lanes_out(b_skewed)
  );

  systolic_array #(.mat_size(mat_size)) u_array (
    .clk(clk),
    .reset(reset),
    .acc_clear(acc_clear),
    .a_lanes(a_skewed),
    .b_lanes(b_skewed),
    .acc(acc)
  );

  result_packer #(.mat_size(mat_size)) u_packer (
    .acc(acc),
    .diag_index(diag_index),
    .c_word(c_word)
  );

endmodule

// File: logic/matmul_ctrl.sv
`timescale 1ns/1ns

module matmul_ctrl #(
  parameter int mat_size = mat_pkg::default_mat_size
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           start_mat_mul,
  input  logic           load_en,
  input  logic           read_en,
  input  logic           we_a,
  input  logic           we_b,
  output mat_pkg::addr_t a_addr,
  output mat_pkg::addr_t b_addr,
  output mat_pkg::addr_t c_addr,
  output logic           operand_valid,
  output logic           acc_clear,
  output logic           c_we,
  output mat_pkg::addr_t diag_index,
  output logic           done_mat_mul
);

  // one word per cycle of feed
  localparam int feed_len = mat_size;
  // last product reaches the far corner 2n-1 cycles after the feed ends
  localparam int drain_len = 2 * mat_size - 1;
  // one C word per diagonal
  localparam int write_len = 2 * mat_size - 1;

  mat_pkg::ctrl_state_t state;
  mat_pkg::addr_t       cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mat_pkg::st_idle;
      cnt <= '0;
    end else if (!start_mat_mul) begin
      // dropping start aborts or retires the run
      state <= mat_pkg::st_idle;
      cnt <= '0;
    end else begin
      case (state)
        mat_pkg::st_idle: begin
          state <= mat_pkg::st_feed;
          cnt <= '0;
        end
        mat_pkg::st_feed: begin
          if (cnt == mat_pkg::addr_t'(feed_len - 1)) begin
            state <= mat_pkg::st_drain;
            cnt <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        mat_pkg::st_drain: begin
          if (cnt == mat_pkg::addr_t'(drain_len - 1)) begin
            state <= mat_pkg::st_write;
            cnt <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        mat_pkg::st_write: begin
          if (cnt == mat_pkg::addr_t'(write_len - 1)) begin
            state <= mat_pkg::st_done;
            cnt <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          // hold st_done until start drops
          state <= state;
        end
      endcase
    end
  end

  // bank data comes back a cycle after the address
  always_ff @(posedge clk) begin
    if (reset) begin
      operand_valid <= 1'b0;
    end else begin
      operand_valid <= start_mat_mul && (state == mat_pkg::st_feed);
    end
  end

  assign a_addr = (state == mat_pkg::st_feed) ? cnt : '0;
  assign b_addr = (state == mat_pkg::st_feed) ? cnt : '0;

  // write address doubles as the diagonal number
  assign diag_index = (state == mat_pkg::st_write) ? cnt : '0;
  assign c_addr = diag_index;
  assign c_we = (state == mat_pkg::st_write);

  assign acc_clear = (state == mat_pkg::st_idle);
  assign done_mat_mul = (state == mat_pkg::st_done);

  // host must keep off the memory port during a run
  host_quiet: assert property (@(posedge clk) disable iff (reset)
    start_mat_mul |-> !(load_en || read_en || we_a || we_b))
    else $error("host memory access while start_mat_mul is high");

  // write burst covers every diagonal, then done follows at once
  write_window: assert property (@(posedge clk) disable iff (reset || !start_mat_mul)
    $rose(c_we) |-> (c_we && state == mat_pkg::st_write) [*write_len]
      ##1 (done_mat_mul && !c_we))
    else $error("C write burst length or done timing wrong");

endmodule

// File: logic/operand_bank.sv
`timescale 1ns/1ns

module operand_bank (
  input  logic           clk,
  input  logic           reset,
  input  logic           host_sel,
  input  mat_pkg::addr_t host_addr,
  input  mat_pkg::addr_t engine_addr,
  input  logic           we,
  input  mat_pkg::word_t wdata,
  output mat_pkg::word_t rdata
);

  mat_pkg::word_t mem [mat_pkg::mem_depth];

  mat_pkg::addr_t addr_q;
  logic           we_q;
  mat_pkg::word_t wdata_q;

  // address select is registered, so read data lands one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      addr_q <= '0;
      we_q <= 1'b0;
    end else begin
      addr_q <= host_sel ? host_addr : engine_addr;
      we_q <= we;
    end
  end

  // write data rides along with the registered address
  always_ff @(posedge clk) begin
    wdata_q <= wdata;
  end

  always_ff @(posedge clk) begin
    if (we_q) begin
      mem[addr_q] <= wdata_q;
    end
  end

  assign rdata = mem[addr_q];

endmodule

// File: logic/result_packer.sv
`timescale 1ns/1ns

module result_packer #(
  parameter int mat_size = mat_pkg::default_mat_size
) (
  input  mat_pkg::acc_t  acc [mat_size*mat_size],
  input  mat_pkg::addr_t diag_index,
  output mat_pkg::word_t c_word
);

  localparam int dw = mat_pkg::data_w;
  localparam int aw = mat_pkg::acc_w;

  for (genvar i = 0; i < mat_pkg::lanes; i++) begin : g_lane
    mat_pkg::data_t lane_val;

    // lane i carries row i, column is diag_index - i
    always_comb begin
      int            col;
      mat_pkg::acc_t sel;
      col = int'(diag_index) - i;
      sel = '0;
      lane_val = '0;
      if (i < mat_size && col >= 0 && col < mat_size) begin
        sel = acc[i*mat_size+col];
        // clamp anything past 16 bits
        if (sel[aw-1:dw] != '0) begin
          lane_val = '1;
        end else begin
          lane_val = sel[dw-1:0];
        end
      end
    end

    assign c_word[i*dw +: dw] = lane_val;
  end

endmodule

// File: logic/operand_skew.sv
`timescale 1ns/1ns

module operand_skew #(
  parameter int mat_size = mat_pkg::default_mat_size
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           operand_valid,
  input  mat_pkg::word_t lanes_in,
  output mat_pkg::word_t lanes_out
);

  localparam int dw = mat_pkg::data_w;

  for (genvar k = 0; k < mat_pkg::lanes; k++) begin : g_lane
    if (k >= mat_size) begin : g_unused
      // lanes past the matrix edge stay quiet
      assign lanes_out[k*dw +: dw] = '0;
    end else begin : g_used
      mat_pkg::data_t head;

      // zeros go in whenever no operand is present
      assign head = operand_valid ? lanes_in[k*dw +: dw] : '0;

      if (k == 0) begin : g_direct
        assign lanes_out[k*dw +: dw] = head;
      end else begin : g_delay
        // k stage shift line
        mat_pkg::data_t taps [0:k-1];

        always_ff @(posedge clk) begin
          if (reset) begin
            for (int t = 0; t < k; t++) begin
              taps[t] <= '0;
            end
          end else begin
            taps[0] <= head;
            for (int t = 1; t < k; t++) begin
              taps[t] <= taps[t-1];
            end
          end
        end

        assign lanes_out[k*dw +: dw] = taps[k-1];
      end
    end
  end

endmodule

// File: logic/systolic_array.sv
`timescale 1ns/1ns

module systolic_array #(
  parameter int mat_size = mat_pkg::default_mat_size
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           acc_clear,
  input  mat_pkg::word_t a_lanes,
  input  mat_pkg::word_t b_lanes,
  output mat_pkg::acc_t  acc [mat_size*mat_size]
);

  localparam int dw = mat_pkg::data_w;

  // a_bus[i][j] feeds cell (i,j) from the west, column mat_size is the east edge
  mat_pkg::data_t a_bus [mat_size][mat_size+1];
  // b_bus[i][j] feeds cell (i,j) from the north, row mat_size is the south edge
  mat_pkg::data_t b_bus [mat_size+1][mat_size];

  // west edge takes A lanes, one row per lane
  for (genvar i = 0; i < mat_size; i++) begin : g_west
    assign a_bus[i][0] = a_lanes[i*dw +: dw];
  end

  // north edge takes B lanes, one column per lane
  for (genvar j = 0; j < mat_size; j++) begin : g_north
    assign b_bus[0][j] = b_lanes[j*dw +: dw];
  end

  for (genvar i = 0; i < mat_size; i++) begin : g_row
    for (genvar j = 0; j < mat_size; j++) begin : g_col
      // cell (i,j) sums row i of A against column j of B
      processing_element u_pe (
        .clk(clk),
        .reset(reset),
        .acc_clear(acc_clear),
        .in_a(a_bus[i][j]),
        .in_b(b_bus[i][j]),
        .out_a(a_bus[i][j+1]),
        .out_b(b_bus[i+1][j]),
        .acc(acc[i*mat_size+j])
      );
    end
  end

endmodule

// File: logic/processing_element.sv
`timescale 1ns/1ns

module processing_element (
  input  logic           clk,
  input  logic           reset,
  input  logic           acc_clear,
  input  mat_pkg::data_t in_a,
  input  mat_pkg::data_t in_b,
  output mat_pkg::data_t out_a,
  output mat_pkg::data_t out_b,
  output mat_pkg::acc_t  acc
);

  mat_pkg::acc_t product;

  // full width product, never overflows 32 bits
  assign product = mat_pkg::acc_t'(in_a) * mat_pkg::acc_t'(in_b);

  always_ff @(posedge clk) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
      acc <= '0;
    end else begin
      // operands move on one cell per cycle
      out_a <= in_a;
      out_b <= in_b;
      // sum wraps at 32 bits
      if (acc_clear) begin
        acc <= '0;
      end else begin
        acc <= acc + product;
      end
    end
  end

endmodule

// File: logic/mat_pkg.sv
package mat_pkg;

  // element and accumulator widths
  localparam int data_w = 16;
  localparam int acc_w = 2 * data_w;

  // one memory word carries a full row of lanes
  localparam int lanes = 4;
  localparam int addr_w = 7;
  localparam int mem_depth = 128;

  // square size used when the top level is not overridden
  localparam int default_mat_size = 4;

  typedef logic [data_w-1:0] data_t;
  typedef logic [acc_w-1:0] acc_t;
  // lane 0 sits in the low bits
  typedef logic [lanes*data_w-1:0] word_t;
  typedef logic [addr_w-1:0] addr_t;

  // controller phases
  typedef enum logic [2:0] {
    st_idle,
    st_feed,
    st_drain,
    st_write,
    st_done
  } ctrl_state_t;

endpackage
